/* hps_control_regs.sv */
/*
 * control registers written by host commands
 *  - config byte with buttons and forced scandoubler
 *  - joysticks 0 and 1, low half first
 *  - 64-bit status, four quarters lowest first
 */

`timescale 1ns/1ps

module hps_control_regs import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  hps_word_s   word,
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output logic [31:0] joystick_0,
	output logic [31:0] joystick_1,
	output logic [63:0] status
);

	// config byte; bits 2, 3 and 5 are video options used outside this core
	logic [7:0] cfg;

	// payload words only, the command word writes nothing
	logic payload;

	assign payload = word.valid && (word.idx != '0);

	// word 1 fills the low half, anything later the high half
	function automatic logic [31:0] joy_update(
		input logic [31:0] joy,
		input word_idx_t   idx,
		input io_word_t    data
	);
		logic [31:0] next;
		next = joy;
		if (idx == 10'd1)
			next[15:0] = data;
		else
			next[31:16] = data;
		return next;
	endfunction

	//////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (payload) begin
			case (word.cmd)
				CMD_CFG: cfg <= word.data[7:0];
				CMD_JOY0: joystick_0 <= joy_update(joystick_0, word.idx, word.data);
				CMD_JOY1: joystick_1 <= joy_update(joystick_1, word.idx, word.data);
				CMD_STATUS: begin
					case (word.idx)
						10'd1: status[15:0]  <= word.data;
						10'd2: status[31:16] <= word.data;
						10'd3: status[47:32] <= word.data;
						10'd4: status[63:48] <= word.data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// config fields
	//////////////////////////////////////////////////

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

endmodule

/* hps_download.sv */
/*
 * file download stage
 *  - menu index and file extension
 *  - start and stop of a download
 *  - byte writes toward memory with address auto-increment
 */

`timescale 1ns/1ps

module hps_download import hps_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  hps_word_s   word,
	output logic        ioctl_download,
	output logic [7:0]  ioctl_index,
	output logic        ioctl_wr,
	output ioctl_addr_t ioctl_addr,
	output logic [7:0]  ioctl_dout,
	output logic [31:0] ioctl_file_ext
);

	// next write address, also the byte count so far
	ioctl_addr_t addr_cnt;
	logic        payload;

	assign payload = word.valid && (word.idx != '0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_file_ext <= '0;
			addr_cnt       <= '0;
		end else begin
			// single cycle write pulse
			ioctl_wr <= 1'b0;

			if (payload) begin
				case (word.cmd)
					CMD_FILE_INDEX: ioctl_index <= word.data[7:0];

					// extension arrives high half first
					CMD_FILE_INFO: begin
						if (word.idx == 10'd1)
							ioctl_file_ext[31:16] <= word.data;
						else if (word.idx == 10'd2)
							ioctl_file_ext[15:0] <= word.data;
					end

					CMD_FILE_TX: begin
						if (word.data[7:0] != 8'h00) begin
							addr_cnt       <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// final byte count on the address lines
							ioctl_addr     <= addr_cnt;
							ioctl_download <= 1'b0;
						end
					end

					CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr_cnt;
						ioctl_dout <= word.data[7:0];
						ioctl_wr   <= 1'b1;
						addr_cnt   <= addr_cnt + 27'd1;
					end

					default: ;
				endcase
			end
		end
	end

endmodule

/* hps_frame_tracker.sv */
/*
 * first pipeline stage of the host channel
 *  - detects frame start on the first strobe
 *  - latches the command word and numbers the payload
 *  - emits one tagged word per strobe, one cycle later
 */

`timescale 1ns/1ps

module hps_frame_tracker import hps_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      io_enable,
	input  logic      io_strobe,
	input  io_word_t  io_din,
	output hps_word_s word,
	output logic      frame_active
);

	frame_state_t state;
	io_word_t     cmd_q;
	word_idx_t    idx_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= FRAME_IDLE;
			cmd_q <= '0;
			idx_q <= '0;
			word  <= '0;
		end else begin
			word.valid <= 1'b0;
			case (state)
				FRAME_IDLE: begin
					// first strobe of a frame carries the command
					if (io_enable && io_strobe) begin
						state      <= FRAME_BODY;
						cmd_q      <= io_din;
						idx_q      <= 10'd1;
						word.valid <= 1'b1;
						word.cmd   <= io_din;
						word.idx   <= '0;
						word.data  <= io_din;
					end
				end
				FRAME_BODY: begin
					if (!io_enable) begin
						state <= FRAME_IDLE;
					end else if (io_strobe) begin
						word.valid <= 1'b1;
						word.cmd   <= cmd_q;
						word.idx   <= idx_q;
						word.data  <= io_din;
						// stick at the top for long frames
						if (~&idx_q)
							idx_q <= idx_q + 10'd1;
					end
				end
				default: state <= FRAME_IDLE;
			endcase
		end
	end

	assign frame_active = (state == FRAME_BODY);

endmodule

/* hps_io_tb.sv */
/*
 * testbench for the host command channel
 *  - host bus frame driver with io_dout sampling
 *  - frame table with random payload and expected replies
 *  - write pulse monitor for the download stage
 *  - value check, per-test report and watchdog
 */

`timescale 1ns/1ps

module hps_io_tb import hps_pkg::*; ();

	localparam int NT   = 11;
	localparam int MAXW = CONF_STR_LEN + 2;
	localparam int DL_N = 5;

	logic clk_sys, reset, io_enable, io_strobe, io_wait, status_set, ioctl_wait;
	io_word_t io_din, io_dout;
	logic [8*CONF_STR_LEN-1:0] conf_str;
	logic [63:0] status_in, status;
	logic [1:0] buttons;
	logic forced_scandoubler, ioctl_download, ioctl_wr;
	logic [31:0] joystick_0, joystick_1, ioctl_file_ext;
	logic [7:0] ioctl_index, ioctl_dout;
	ioctl_addr_t ioctl_addr;

	integer seed;
	int err_count, test_count, fail_count, wr_count, n_tbl, total_words, errs_before;
	logic tbl_ready;
	logic [63:0] st_first, st_cap;
	string conf_text;

	// frame table, word 0 is the command
	io_word_t tbl_cmd [NT];
	int tbl_len [NT];
	io_word_t tbl_pay [NT][MAXW+1];
	io_word_t tbl_resp [NT][MAXW+1];
	logic [63:0] tbl_exp [NT];
	logic [7:0] dl_bytes [$];

	hps_io_top hps_io_top_i (.*);

	always #2 clk_sys = ~clk_sys;

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
			err_count++;
		end
	endtask

	//////////////////////////////////////////////////
	// table setup
	//////////////////////////////////////////////////

	task automatic add_frame(input io_word_t cmd, input int len);
		tbl_cmd[n_tbl] = cmd;
		tbl_len[n_tbl] = len;
		tbl_exp[n_tbl] = '0;
		tbl_pay[n_tbl][0] = cmd;
		for (int i = 0; i <= MAXW; i++)
			tbl_resp[n_tbl][i] = '0;
		for (int i = 1; i <= len; i++)
			tbl_pay[n_tbl][i] = io_word_t'($random(seed));
		n_tbl++;
	endtask

	task automatic build_table();
		int t;
		add_frame(CMD_CFG, 1);
		t = n_tbl - 1;
		tbl_exp[t] = 64'({tbl_pay[t][1][4], tbl_pay[t][1][1:0]});
		for (int j = 0; j < 2; j++) begin
			add_frame(j == 0 ? CMD_JOY0 : CMD_JOY1, 2);
			t = n_tbl - 1;
			tbl_exp[t] = 64'({tbl_pay[t][2], tbl_pay[t][1]});
		end
		add_frame(CMD_STATUS, 4);
		t = n_tbl - 1;
		tbl_exp[t] = {tbl_pay[t][4], tbl_pay[t][3], tbl_pay[t][2], tbl_pay[t][1]};
		// two status_set edges are sent before this frame
		add_frame(CMD_STATUS_REQ, 4);
		t = n_tbl - 1;
		tbl_resp[t][0] = {8'h00, STATUS_REQ_TAG, 4'd2};
		for (int i = 1; i <= 4; i++)
			tbl_resp[t][i] = st_cap[16*(i-1) +: 16];
		add_frame(CMD_CONF_STR, CONF_STR_LEN + 2);
		t = n_tbl - 1;
		for (int i = 1; i <= CONF_STR_LEN; i++)
			tbl_resp[t][i] = {8'h00, conf_text[i-1]};
		add_frame(CMD_FILE_INDEX, 1);
		t = n_tbl - 1;
		tbl_exp[t] = 64'(tbl_pay[t][1][7:0]);
		add_frame(CMD_FILE_INFO, 2);
		t = n_tbl - 1;
		tbl_exp[t] = 64'({tbl_pay[t][1], tbl_pay[t][2]});
		add_frame(CMD_FILE_TX, 1);
		t = n_tbl - 1;
		tbl_pay[t][1][0] = 1'b1;
		tbl_exp[t] = 64'd1;
		add_frame(CMD_FILE_TX_DAT, DL_N);
		t = n_tbl - 1;
		for (int i = 1; i <= DL_N; i++)
			dl_bytes.push_back(tbl_pay[t][i][7:0]);
		tbl_exp[t] = 64'(DL_N);
		add_frame(CMD_FILE_TX, 1);
		t = n_tbl - 1;
		tbl_pay[t][1][7:0] = 8'h00;
		tbl_exp[t] = 64'(DL_N);
	endtask

	//////////////////////////////////////////////////
	// host bus driver and result checks
	//////////////////////////////////////////////////

	// one strobe every third cycle, reply sampled two cycles after it
	task automatic send_frame(input int t);
		io_enable = 1'b1;
		for (int i = 0; i <= tbl_len[t]; i++) begin
			while (io_wait) begin
				@(posedge clk_sys);
				#1;
			end
			io_strobe = 1'b1;
			io_din = tbl_pay[t][i];
			@(posedge clk_sys);
			#1 io_strobe = 1'b0;
			@(posedge clk_sys);
			#1 check_value($sformatf("io_dout word %0d", i), 64'(tbl_resp[t][i]), 64'(io_dout));
			@(posedge clk_sys);
			#1;
		end
		io_enable = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	task automatic check_entry(input int t);
		case (tbl_cmd[t])
			CMD_CFG: begin
				check_value("buttons", 64'(tbl_exp[t][1:0]), 64'(buttons));
				check_value("forced_scandoubler", 64'(tbl_exp[t][2]), 64'(forced_scandoubler));
			end
			CMD_JOY0: check_value("joystick_0", tbl_exp[t], 64'(joystick_0));
			CMD_JOY1: check_value("joystick_1", tbl_exp[t], 64'(joystick_1));
			CMD_STATUS: check_value("status", tbl_exp[t], status);
			CMD_FILE_INDEX: check_value("ioctl_index", tbl_exp[t], 64'(ioctl_index));
			CMD_FILE_INFO: check_value("ioctl_file_ext", tbl_exp[t], 64'(ioctl_file_ext));
			CMD_FILE_TX: begin
				if (tbl_pay[t][1][7:0] != 8'h00) begin
					check_value("ioctl_download", tbl_exp[t], 64'(ioctl_download));
				end else begin
					check_value("ioctl_download", 64'd0, 64'(ioctl_download));
					check_value("ioctl_addr", tbl_exp[t], 64'(ioctl_addr));
					check_value("write count", tbl_exp[t], 64'(wr_count));
				end
			end
			CMD_FILE_TX_DAT: check_value("write count", tbl_exp[t], 64'(wr_count));
			default: ;
		endcase
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (err_count == errs_before) begin
			$display("test %0d %s ok", test_count, name);
		end else begin
			fail_count++;
			$display("test %0d %s FAIL", test_count, name);
		end
	endtask

	task automatic pulse_status_set(input logic [63:0] value);
		status_in = value;
		status_set = 1'b1;
		@(posedge clk_sys);
		#1 status_set = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	// pulse k carries address k and the k-th data byte
	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr) begin
			if (wr_count < dl_bytes.size()) begin
				check_value("ioctl_addr", 64'(wr_count), 64'(ioctl_addr));
				check_value("ioctl_dout", 64'(dl_bytes[wr_count]), 64'(ioctl_dout));
			end else begin
				$display("write pulse %0d at %0t ns has no data word to match", wr_count, $time);
				err_count++;
			end
			wr_count++;
		end
	end

	initial begin
		wait (tbl_ready);
		repeat (total_words * 3 + 200) @(posedge clk_sys);
		$display("timeout, the frames did not finish within %0d cycles", total_words * 3 + 200);
		$display("sim failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		err_count = 0;
		test_count = 0;
		fail_count = 0;
		wr_count = 0;
		n_tbl = 0;
		total_words = 0;
		tbl_ready = 1'b0;
		seed = 32'h54d8;
		conf_text = "CORE;;O12,Scan;;";
		conf_str = '0;
		// first character ends up in the top byte
		for (int i = 0; i < CONF_STR_LEN; i++)
			conf_str = {conf_str[8*CONF_STR_LEN-9:0], conf_text[i]};
		st_first = {$random(seed), $random(seed)};
		st_cap = {$random(seed), $random(seed)};
		build_table();
		for (int t = 0; t < n_tbl; t++)
			total_words += tbl_len[t] + 1;
		tbl_ready = 1'b1;

		repeat (4) @(posedge clk_sys);
		#1 reset = 1'b0;
		pulse_status_set(st_first);
		pulse_status_set(st_cap);
		// status_in moves on, the reply must still show the value at the edge
		status_in = st_first;

		for (int t = 0; t < n_tbl; t++) begin
			errs_before = err_count;
			send_frame(t);
			check_entry(t);
			end_test($sformatf("cmd %h", tbl_cmd[t]));
		end

		errs_before = err_count;
		ioctl_wait = 1'b1;
		@(posedge clk_sys);
		#1 check_value("io_wait", 64'd1, 64'(io_wait));
		ioctl_wait = 1'b0;
		@(posedge clk_sys);
		#1 check_value("io_wait", 64'd0, 64'(io_wait));
		end_test("io_wait");

		$display("tests %0d, failed %0d, errors %0d, write pulses %0d",
			test_count, fail_count, err_count, wr_count);
		if (err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* hps_io_top.sv */
/*
 * top level of the host command channel
 *  - frame tracker feeding three parallel stages
 *  - control registers, download and read-back
 *  - host wait taken straight from the memory writer
 */

`timescale 1ns/1ps

module hps_io_top import hps_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,

	// host bus
	input  logic                      io_enable,
	input  logic                      io_strobe,
	input  io_word_t                  io_din,
	output io_word_t                  io_dout,
	output logic                      io_wait,

	// core side
	input  logic [8*CONF_STR_LEN-1:0] conf_str,
	input  logic [63:0]               status_in,
	input  logic                      status_set,
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output logic [31:0]               joystick_0,
	output logic [31:0]               joystick_1,
	output logic [63:0]               status,

	// download
	output logic                      ioctl_download,
	output logic [7:0]                ioctl_index,
	output logic                      ioctl_wr,
	output ioctl_addr_t               ioctl_addr,
	output logic [7:0]                ioctl_dout,
	output logic [31:0]               ioctl_file_ext,
	input  logic                      ioctl_wait
);

	hps_word_s word;
	logic      frame_active;

	// only back-pressure toward the host
	assign io_wait = ioctl_wait;

	hps_frame_tracker hps_frame_tracker_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.io_enable    (io_enable),
		.io_strobe    (io_strobe),
		.io_din       (io_din),
		.word         (word),
		.frame_active (frame_active)
	);

	hps_control_regs hps_control_regs_i (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.word               (word),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	hps_download hps_download_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.word           (word),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	hps_readback hps_readback_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.word         (word),
		.frame_active (frame_active),
		.conf_str     (conf_str),
		.status_in    (status_in),
		.status_set   (status_set),
		.io_dout      (io_dout)
	);

endmodule

/* hps_pkg.sv */
/*
 * shared definitions for the host command channel
 *  - host bus word and frame index types
 *  - control and download command codes
 *  - config string size and status-request reply tag
 *  - frame tracker states and the pipeline word struct
 */

package hps_pkg;

	//////////////////////////////////////////////////
	// basic types
	//////////////////////////////////////////////////

	// one word on the host bus
	typedef logic [15:0] io_word_t;

	// word position in a frame, 0 is the command word
	typedef logic [9:0] word_idx_t;

	// byte address of a download
	typedef logic [26:0] ioctl_addr_t;

	//////////////////////////////////////////////////
	// command codes
	//////////////////////////////////////////////////

	// control
	localparam io_word_t CMD_CFG         = 16'h0001;
	localparam io_word_t CMD_JOY0        = 16'h0002;
	localparam io_word_t CMD_JOY1        = 16'h0003;
	localparam io_word_t CMD_CONF_STR    = 16'h0014;
	localparam io_word_t CMD_STATUS      = 16'h001E;
	localparam io_word_t CMD_STATUS_REQ  = 16'h0029;

	// file download
	localparam io_word_t CMD_FILE_TX     = 16'h0053;
	localparam io_word_t CMD_FILE_TX_DAT = 16'h0054;
	localparam io_word_t CMD_FILE_INDEX  = 16'h0055;
	localparam io_word_t CMD_FILE_INFO   = 16'h0056;

	// config string length in bytes
	localparam int CONF_STR_LEN = 16;

	// upper nibble of the status-request reply
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	//////////////////////////////////////////////////
	// pipeline
	//////////////////////////////////////////////////

	typedef enum logic {
		FRAME_IDLE,
		FRAME_BODY
	} frame_state_t;

	// a host word tagged with its frame command and position
	typedef struct packed {
		logic      valid;
		io_word_t  cmd;
		word_idx_t idx;
		io_word_t  data;
	} hps_word_s;

endpackage

/* hps_readback.sv */
/*
 * read-back stage of the host channel
 *  - status-set edge counter with captured status
 *  - status-request and config string replies
 *  - registered response word on io_dout
 */

`timescale 1ns/1ps

module hps_readback import hps_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  hps_word_s                 word,
	input  logic                      frame_active,
	input  logic [8*CONF_STR_LEN-1:0] conf_str,
	input  logic [63:0]               status_in,
	input  logic                      status_set,
	output io_word_t                  io_dout
);

	logic        status_set_d;
	logic [3:0]  req_cnt;
	logic [63:0] status_req;
	io_word_t    resp;

	//////////////////////////////////////////////////
	// status-set requests
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_d <= 1'b0;
			req_cnt      <= '0;
			status_req   <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				req_cnt    <= req_cnt + 4'd1;
				status_req <= status_in;
			end
		end
	end

	//////////////////////////////////////////////////
	// response
	//////////////////////////////////////////////////

	always_comb begin
		resp = '0;
		if (word.idx == '0) begin
			if (word.cmd == CMD_STATUS_REQ)
				resp = {8'h00, STATUS_REQ_TAG, req_cnt};
		end else begin
			case (word.cmd)
				CMD_STATUS_REQ: begin
					case (word.idx)
						10'd1: resp = status_req[15:0];
						10'd2: resp = status_req[31:16];
						10'd3: resp = status_req[47:32];
						10'd4: resp = status_req[63:48];
						default: resp = '0;
					endcase
				end
				// string is read from its most significant byte
				CMD_CONF_STR: begin
					if (word.idx <= word_idx_t'(CONF_STR_LEN))
						resp[7:0] = conf_str[(CONF_STR_LEN - int'(word.idx)) * 8 +: 8];
				end
				default: resp = '0;
			endcase
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			io_dout <= '0;
		else if (!frame_active)
			io_dout <= '0;
		else if (word.valid)
			io_dout <= resp;
	end

endmodule

/* project.f */
hps_pkg.sv
hps_frame_tracker.sv
hps_control_regs.sv
hps_download.sv
hps_readback.sv
hps_io_top.sv
hps_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f project.f --top-module hps_io_tb -o hps_io_sim \
	&& ./obj_dir/hps_io_sim | tee sim.log \
	|| { echo "build or run error"; exit 1; }
grep -q "sim failed" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "sim passed" sim.log || { echo "no result found in log"; exit 1; }
echo "simulation ok"
exit 0
